// ==== axi_pkg.sv ====
`default_nettype none

package axi_pkg;

  localparam int AXI_ID_BITS   = 4;
  localparam int AXI_IDS_BITS  = 8;
  localparam int AXI_ADDR_BITS = 32;
  localparam int AXI_DATA_BITS = 32;
  localparam int AXI_STRB_BITS = 4;
  localparam int AXI_LEN_BITS  = 4;
  localparam int AXI_SIZE_BITS = 3;

  // Upper part of the slave-side ID
  localparam logic [AXI_IDS_BITS-AXI_ID_BITS-1:0] AXI_MASTER_1_ID = 4'd1;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  typedef enum logic {
    LOCK_FREE,
    LOCK_M1
  } addr_arb_lock_t;

  typedef enum logic [1:0] {
    SLAVE_0,
    SLAVE_1,
    SLAVE_2
  } slave_sel_t;

  // 64 KiB windows at 0x0000_0000 and 0x0001_0000, the rest is unmapped
  function automatic slave_sel_t addr_decoder(input logic [AXI_ADDR_BITS-1:0] addr);
    slave_sel_t sel;
    case (addr[AXI_ADDR_BITS-1:16])
      16'h0000: sel = SLAVE_0;
      16'h0001: sel = SLAVE_1;
      default:  sel = SLAVE_2;
    endcase
    return sel;
  endfunction

endpackage

`default_nettype wire

// ==== axi_chan_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface axi_aw_if;
  import axi_pkg::*;

  logic [AXI_IDS_BITS-1:0]  awid;
  logic [AXI_ADDR_BITS-1:0] awaddr;
  logic [AXI_LEN_BITS-1:0]  awlen;
  logic [AXI_SIZE_BITS-1:0] awsize;
  logic [1:0]               awburst;
  logic                     awvalid;
  logic                     awready;

  modport mst (output awid, awaddr, awlen, awsize, awburst, awvalid,
               input  awready);
  modport slv (input  awid, awaddr, awlen, awsize, awburst, awvalid,
               output awready);
endinterface

interface axi_w_if;
  import axi_pkg::*;

  logic [AXI_DATA_BITS-1:0] wdata;
  logic [AXI_STRB_BITS-1:0] wstrb;
  logic                     wlast;
  logic                     wvalid;
  logic                     wready;

  modport mst (output wdata, wstrb, wlast, wvalid, input wready);
  modport slv (input wdata, wstrb, wlast, wvalid, output wready);
endinterface

// Source of B is the slave, so mst sits on the slave side
interface axi_b_if;
  import axi_pkg::*;

  logic [AXI_IDS_BITS-1:0] bid;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;

  modport mst (output bid, bresp, bvalid, input bready);
  modport slv (input bid, bresp, bvalid, output bready);
endinterface

`default_nettype wire

// ==== aw_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module aw_router (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [axi_pkg::AXI_ID_BITS-1:0]   awid,
  input  logic [axi_pkg::AXI_ADDR_BITS-1:0] awaddr,
  input  logic [axi_pkg::AXI_LEN_BITS-1:0]  awlen,
  input  logic [axi_pkg::AXI_SIZE_BITS-1:0] awsize,
  input  logic [1:0]                        awburst,
  input  logic                              awvalid,
  output logic                              awready,
  axi_aw_if.mst                             s0,
  axi_aw_if.mst                             s1,
  axi_aw_if.mst                             s2,
  output logic                              route_busy,
  output axi_pkg::slave_sel_t               wr_target,
  input  logic                              b_done
);
  import axi_pkg::*;

  addr_arb_lock_t          lock_q;
  addr_arb_lock_t          lock_d;
  slave_sel_t              dec_sel;
  slave_sel_t              held_sel;
  slave_sel_t              cur_sel;
  logic [AXI_IDS_BITS-1:0] slv_id;
  logic                    fwd_valid;
  logic                    sel_ready;
  logic                    aw_hs;
  logic                    hit0;
  logic                    hit1;
  logic                    hit2;

  assign dec_sel   = addr_decoder(awaddr);
  assign slv_id    = {AXI_MASTER_1_ID, awid};
  // No new address reaches a slave while a write is outstanding
  assign fwd_valid = awvalid & ~route_busy;

  // Lock holds the slave choice while a presented request waits for ready
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q <= LOCK_FREE;
    end else begin
      lock_q <= lock_d;
    end
  end

  always_comb begin
    case (lock_q)
      LOCK_FREE: lock_d = (fwd_valid && !sel_ready) ? LOCK_M1 : LOCK_FREE;
      LOCK_M1:   lock_d = sel_ready ? LOCK_FREE : LOCK_M1;
      default:   lock_d = LOCK_FREE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (lock_q == LOCK_FREE) begin
      held_sel <= dec_sel;
    end
  end

  assign cur_sel = (lock_q == LOCK_M1) ? held_sel : dec_sel;

  always_comb begin
    case (cur_sel)
      SLAVE_0: sel_ready = s0.awready;
      SLAVE_1: sel_ready = s1.awready;
      default: sel_ready = s2.awready;
    endcase
  end

  assign awready = sel_ready & ~route_busy;
  assign aw_hs   = awvalid & awready;

  assign hit0 = (cur_sel == SLAVE_0);
  assign hit1 = (cur_sel == SLAVE_1);
  assign hit2 = (cur_sel == SLAVE_2);

  // Only the selected slave sees the request, others stay zero
  assign s0.awvalid = hit0 & fwd_valid;
  assign s0.awid    = hit0 ? slv_id : '0;
  assign s0.awaddr  = hit0 ? awaddr : '0;
  assign s0.awlen   = hit0 ? awlen : '0;
  assign s0.awsize  = hit0 ? awsize : '0;
  assign s0.awburst = hit0 ? awburst : '0;

  assign s1.awvalid = hit1 & fwd_valid;
  assign s1.awid    = hit1 ? slv_id : '0;
  assign s1.awaddr  = hit1 ? awaddr : '0;
  assign s1.awlen   = hit1 ? awlen : '0;
  assign s1.awsize  = hit1 ? awsize : '0;
  assign s1.awburst = hit1 ? awburst : '0;

  assign s2.awvalid = hit2 & fwd_valid;
  assign s2.awid    = hit2 ? slv_id : '0;
  assign s2.awaddr  = hit2 ? awaddr : '0;
  assign s2.awlen   = hit2 ? awlen : '0;
  assign s2.awsize  = hit2 ? awsize : '0;
  assign s2.awburst = hit2 ? awburst : '0;

  // Route record for the W and B paths
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      route_busy <= 1'b0;
      wr_target  <= SLAVE_2;
    end else if (aw_hs) begin
      route_busy <= 1'b1;
      wr_target  <= cur_sel;
    end else if (b_done) begin
      route_busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== w_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module w_router (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [axi_pkg::AXI_DATA_BITS-1:0] wdata,
  input  logic [axi_pkg::AXI_STRB_BITS-1:0] wstrb,
  input  logic                              wlast,
  input  logic                              wvalid,
  output logic                              wready,
  axi_w_if.mst                              s0,
  axi_w_if.mst                              s1,
  axi_w_if.mst                              s2,
  input  axi_pkg::slave_sel_t               wr_target,
  input  logic                              route_busy,
  output logic                              w_done
);
  import axi_pkg::*;

  logic data_open;
  logic sel_ready;
  logic hit0;
  logic hit1;
  logic hit2;

  // Data phase runs from the AW handshake until the last beat
  assign data_open = route_busy & ~w_done;

  assign hit0 = data_open & (wr_target == SLAVE_0);
  assign hit1 = data_open & (wr_target == SLAVE_1);
  assign hit2 = data_open & (wr_target == SLAVE_2);

  assign s0.wvalid = hit0 & wvalid;
  assign s0.wdata  = hit0 ? wdata : '0;
  assign s0.wstrb  = hit0 ? wstrb : '0;
  assign s0.wlast  = hit0 & wlast;

  assign s1.wvalid = hit1 & wvalid;
  assign s1.wdata  = hit1 ? wdata : '0;
  assign s1.wstrb  = hit1 ? wstrb : '0;
  assign s1.wlast  = hit1 & wlast;

  assign s2.wvalid = hit2 & wvalid;
  assign s2.wdata  = hit2 ? wdata : '0;
  assign s2.wstrb  = hit2 ? wstrb : '0;
  assign s2.wlast  = hit2 & wlast;

  always_comb begin
    case (wr_target)
      SLAVE_0: sel_ready = s0.wready;
      SLAVE_1: sel_ready = s1.wready;
      default: sel_ready = s2.wready;
    endcase
  end

  assign wready = data_open & sel_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      w_done <= 1'b0;
    end else if (!route_busy) begin
      w_done <= 1'b0;
    end else if (wvalid && wready && wlast) begin
      w_done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== b_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module b_router (
  input  logic                            clk,
  input  logic                            rstn,
  axi_b_if.slv                            s0,
  axi_b_if.slv                            s1,
  axi_b_if.slv                            s2,
  input  axi_pkg::slave_sel_t             wr_target,
  input  logic                            w_done,
  output logic [axi_pkg::AXI_ID_BITS-1:0] bid,
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  logic                            bready,
  output logic                            b_done
);
  import axi_pkg::*;

  logic b_seen;
  logic live;
  logic sel_valid;

  // One response per write, blocked again until the route closes
  assign live = w_done & ~b_seen;

  always_comb begin
    case (wr_target)
      SLAVE_0: begin
        sel_valid = s0.bvalid;
        bid       = s0.bid[AXI_ID_BITS-1:0];
        bresp     = s0.bresp;
      end
      SLAVE_1: begin
        sel_valid = s1.bvalid;
        bid       = s1.bid[AXI_ID_BITS-1:0];
        bresp     = s1.bresp;
      end
      default: begin
        sel_valid = s2.bvalid;
        bid       = s2.bid[AXI_ID_BITS-1:0];
        bresp     = s2.bresp;
      end
    endcase
  end

  assign bvalid = live & sel_valid;
  assign b_done = bvalid & bready;

  assign s0.bready = live & bready & (wr_target == SLAVE_0);
  assign s1.bready = live & bready & (wr_target == SLAVE_1);
  assign s2.bready = live & bready & (wr_target == SLAVE_2);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      b_seen <= 1'b0;
    end else if (!w_done) begin
      b_seen <= 1'b0;
    end else if (b_done) begin
      b_seen <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== default_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module default_slave (
  input logic   clk,
  input logic   rstn,
  axi_aw_if.slv aw,
  axi_w_if.slv  w,
  axi_b_if.mst  b
);
  import axi_pkg::*;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_DRAIN = 2'd1;
  localparam logic [1:0] ST_RESP  = 2'd2;

  logic [1:0]              state;
  logic [AXI_IDS_BITS-1:0] id_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aw.awvalid) begin
            state <= ST_DRAIN;
          end
        end
        // Data beats are thrown away
        ST_DRAIN: begin
          if (w.wvalid && w.wlast) begin
            state <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (b.bready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw.awvalid && aw.awready) begin
      id_q <= aw.awid;
    end
  end

  assign aw.awready = (state == ST_IDLE);
  assign w.wready   = (state == ST_DRAIN);
  assign b.bvalid   = (state == ST_RESP);
  assign b.bid      = id_q;
  assign b.bresp    = RESP_DECERR;

endmodule

`default_nettype wire

// ==== axi_wr_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_wr_bridge (
  input  logic                              clk,
  input  logic                              rstn,
  // Master
  input  logic [axi_pkg::AXI_ID_BITS-1:0]   awid,
  input  logic [axi_pkg::AXI_ADDR_BITS-1:0] awaddr,
  input  logic [axi_pkg::AXI_LEN_BITS-1:0]  awlen,
  input  logic [axi_pkg::AXI_SIZE_BITS-1:0] awsize,
  input  logic [1:0]                        awburst,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [axi_pkg::AXI_DATA_BITS-1:0] wdata,
  input  logic [axi_pkg::AXI_STRB_BITS-1:0] wstrb,
  input  logic                              wlast,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [axi_pkg::AXI_ID_BITS-1:0]   bid,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  // Slave 0
  output logic [axi_pkg::AXI_IDS_BITS-1:0]  s0_awid,
  output logic [axi_pkg::AXI_ADDR_BITS-1:0] s0_awaddr,
  output logic [axi_pkg::AXI_LEN_BITS-1:0]  s0_awlen,
  output logic [axi_pkg::AXI_SIZE_BITS-1:0] s0_awsize,
  output logic [1:0]                        s0_awburst,
  output logic                              s0_awvalid,
  input  logic                              s0_awready,
  output logic [axi_pkg::AXI_DATA_BITS-1:0] s0_wdata,
  output logic [axi_pkg::AXI_STRB_BITS-1:0] s0_wstrb,
  output logic                              s0_wlast,
  output logic                              s0_wvalid,
  input  logic                              s0_wready,
  input  logic [axi_pkg::AXI_IDS_BITS-1:0]  s0_bid,
  input  logic [1:0]                        s0_bresp,
  input  logic                              s0_bvalid,
  output logic                              s0_bready,
  // Slave 1
  output logic [axi_pkg::AXI_IDS_BITS-1:0]  s1_awid,
  output logic [axi_pkg::AXI_ADDR_BITS-1:0] s1_awaddr,
  output logic [axi_pkg::AXI_LEN_BITS-1:0]  s1_awlen,
  output logic [axi_pkg::AXI_SIZE_BITS-1:0] s1_awsize,
  output logic [1:0]                        s1_awburst,
  output logic                              s1_awvalid,
  input  logic                              s1_awready,
  output logic [axi_pkg::AXI_DATA_BITS-1:0] s1_wdata,
  output logic [axi_pkg::AXI_STRB_BITS-1:0] s1_wstrb,
  output logic                              s1_wlast,
  output logic                              s1_wvalid,
  input  logic                              s1_wready,
  input  logic [axi_pkg::AXI_IDS_BITS-1:0]  s1_bid,
  input  logic [1:0]                        s1_bresp,
  input  logic                              s1_bvalid,
  output logic                              s1_bready
);
  import axi_pkg::*;

  slave_sel_t wr_target;
  logic       route_busy;
  logic       w_done;
  logic       b_done;

  axi_aw_if aw_s0 ();
  axi_aw_if aw_s1 ();
  axi_aw_if aw_s2 ();
  axi_w_if  w_s0 ();
  axi_w_if  w_s1 ();
  axi_w_if  w_s2 ();
  axi_b_if  b_s0 ();
  axi_b_if  b_s1 ();
  axi_b_if  b_s2 ();

  // Master side names match the router ports
  aw_router u_aw_router (.*, .s0(aw_s0), .s1(aw_s1), .s2(aw_s2));
  w_router  u_w_router  (.*, .s0(w_s0), .s1(w_s1), .s2(w_s2));
  b_router  u_b_router  (.*, .s0(b_s0), .s1(b_s1), .s2(b_s2));

  // Unmapped addresses end here
  default_slave u_default_slave (
    .clk  (clk),
    .rstn (rstn),
    .aw   (aw_s2),
    .w    (w_s2),
    .b    (b_s2)
  );

  assign s0_awid       = aw_s0.awid;
  assign s0_awaddr     = aw_s0.awaddr;
  assign s0_awlen      = aw_s0.awlen;
  assign s0_awsize     = aw_s0.awsize;
  assign s0_awburst    = aw_s0.awburst;
  assign s0_awvalid    = aw_s0.awvalid;
  assign aw_s0.awready = s0_awready;
  assign s0_wdata      = w_s0.wdata;
  assign s0_wstrb      = w_s0.wstrb;
  assign s0_wlast      = w_s0.wlast;
  assign s0_wvalid     = w_s0.wvalid;
  assign w_s0.wready   = s0_wready;
  assign b_s0.bid      = s0_bid;
  assign b_s0.bresp    = s0_bresp;
  assign b_s0.bvalid   = s0_bvalid;
  assign s0_bready     = b_s0.bready;

  assign s1_awid       = aw_s1.awid;
  assign s1_awaddr     = aw_s1.awaddr;
  assign s1_awlen      = aw_s1.awlen;
  assign s1_awsize     = aw_s1.awsize;
  assign s1_awburst    = aw_s1.awburst;
  assign s1_awvalid    = aw_s1.awvalid;
  assign aw_s1.awready = s1_awready;
  assign s1_wdata      = w_s1.wdata;
  assign s1_wstrb      = w_s1.wstrb;
  assign s1_wlast      = w_s1.wlast;
  assign s1_wvalid     = w_s1.wvalid;
  assign w_s1.wready   = s1_wready;
  assign b_s1.bid      = s1_bid;
  assign b_s1.bresp    = s1_bresp;
  assign b_s1.bvalid   = s1_bvalid;
  assign s1_bready     = b_s1.bready;

endmodule

`default_nettype wire

// ==== tb_axi_wr_bridge_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module aw_bridge_props (
  input logic clk,
  input logic rstn,
  input logic v0,
  input logic v1,
  input logic v2,
  input logic r0,
  input logic r1,
  input logic awready,
  input logic route_busy,
  input logic b_done
);

  a_one_slave: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({v0, v1, v2})) else $error("more than one slave AWVALID high");

  // Busy lasts until the B handshake, so AWREADY stays low the cycle after
  a_no_ready_busy: assert property (@(posedge clk) disable iff (!rstn)
    route_busy && !b_done |=> !awready) else $error("AWREADY high during outstanding write");

  a_hold_s0: assert property (@(posedge clk) disable iff (!rstn)
    v0 && !r0 |=> v0) else $error("slave 0 AWVALID dropped before AWREADY");

  a_hold_s1: assert property (@(posedge clk) disable iff (!rstn)
    v1 && !r1 |=> v1) else $error("slave 1 AWVALID dropped before AWREADY");

endmodule

bind aw_router aw_bridge_props u_props (
  .clk(clk), .rstn(rstn),
  .v0(s0.awvalid), .v1(s1.awvalid), .v2(s2.awvalid),
  .r0(s0.awready), .r1(s1.awready),
  .awready(awready), .route_busy(route_busy), .b_done(b_done)
);

`default_nettype wire

// ==== tb_axi_wr_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_bridge;

  localparam int N_WRITES = 40;
  localparam int CLK_NS   = 8;

  logic        clk;
  logic        rstn;
  logic [3:0]  awid;
  logic [31:0] awaddr;
  logic [3:0]  awlen;
  logic [2:0]  awsize;
  logic [1:0]  awburst;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  logic [3:0]  bid;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;

  // Slave side, index 0 and 1
  logic [7:0]  s_awid [2];
  logic [31:0] s_awaddr [2];
  logic [3:0]  s_awlen [2];
  logic [2:0]  s_awsize [2];
  logic [1:0]  s_awburst [2];
  logic        s_awvalid [2];
  logic        s_awready [2];
  logic [31:0] s_wdata [2];
  logic [3:0]  s_wstrb [2];
  logic        s_wlast [2];
  logic        s_wvalid [2];
  logic        s_wready [2];
  logic [7:0]  s_bid [2];
  logic [1:0]  s_bresp [2];
  logic        s_bvalid [2];
  logic        s_bready [2];

  // What each slave model saw during the current write
  int          rec_aw_cnt [2];
  int          rec_beats [2];
  int          valid_seen [2];
  logic [7:0]  rec_id [2];
  logic [31:0] rec_addr [2];
  logic [3:0]  rec_len [2];
  logic [2:0]  rec_size [2];
  logic [1:0]  rec_burst [2];
  logic [31:0] rec_data [2][16];
  logic [3:0]  rec_strb [2][16];
  logic        rec_last [2][16];

  // Address, ID and length of every write
  logic [31:0] wr_addr [N_WRITES];
  logic [3:0]  wr_id [N_WRITES];
  logic [3:0]  wr_len [N_WRITES];

  // Master side record of the current write
  logic [31:0] cur_addr;
  logic [3:0]  cur_id;
  logic [3:0]  cur_len;
  logic [31:0] cur_data [4];
  logic [3:0]  cur_strb [4];
  logic [3:0]  got_bid;
  logic [1:0]  got_bresp;
  logic        pending;
  int          errors;
  int unsigned rng_state;
  event        write_done;

  axi_wr_bridge u_dut (
    .clk(clk), .rstn(rstn),
    .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
    .awburst(awburst), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
    .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .s0_awid(s_awid[0]), .s0_awaddr(s_awaddr[0]), .s0_awlen(s_awlen[0]),
    .s0_awsize(s_awsize[0]), .s0_awburst(s_awburst[0]),
    .s0_awvalid(s_awvalid[0]), .s0_awready(s_awready[0]),
    .s0_wdata(s_wdata[0]), .s0_wstrb(s_wstrb[0]), .s0_wlast(s_wlast[0]),
    .s0_wvalid(s_wvalid[0]), .s0_wready(s_wready[0]),
    .s0_bid(s_bid[0]), .s0_bresp(s_bresp[0]), .s0_bvalid(s_bvalid[0]),
    .s0_bready(s_bready[0]),
    .s1_awid(s_awid[1]), .s1_awaddr(s_awaddr[1]), .s1_awlen(s_awlen[1]),
    .s1_awsize(s_awsize[1]), .s1_awburst(s_awburst[1]),
    .s1_awvalid(s_awvalid[1]), .s1_awready(s_awready[1]),
    .s1_wdata(s_wdata[1]), .s1_wstrb(s_wstrb[1]), .s1_wlast(s_wlast[1]),
    .s1_wvalid(s_wvalid[1]), .s1_wready(s_wready[1]),
    .s1_bid(s_bid[1]), .s1_bresp(s_bresp[1]), .s1_bvalid(s_bvalid[1]),
    .s1_bready(s_bready[1])
  );

  always #(CLK_NS / 2) clk = ~clk;

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state >> 8;
  endfunction

  // Target slave by the address map, slave-side ID and response code
  function automatic int expected_write(input logic [31:0] addr, input logic [3:0] id,
                                        output logic [7:0] ids, output logic [1:0] resp);
    int target;
    if (addr < 32'h0001_0000) begin
      target = 0;
    end else if (addr < 32'h0002_0000) begin
      target = 1;
    end else begin
      target = 2;
    end
    ids  = {4'h1, id};
    resp = (target == 2) ? 2'b11 : 2'b00;
    return target;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    assert (exp === act) else begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic slave_model(input int k);
    logic hs;
    int   gap;
    forever begin
      do @(negedge clk); while (!s_awvalid[k]);
      repeat (lcg_next() % 4) @(posedge clk);
      @(posedge clk);
      #1 s_awready[k] = 1'b1;
      do begin
        @(negedge clk);
        hs = s_awvalid[k] && s_awready[k];
        if (hs) begin
          rec_aw_cnt[k]++;
          rec_id[k]    = s_awid[k];
          rec_addr[k]  = s_awaddr[k];
          rec_len[k]   = s_awlen[k];
          rec_size[k]  = s_awsize[k];
          rec_burst[k] = s_awburst[k];
        end
        @(posedge clk);
      end while (!hs);
      #1 s_awready[k] = 1'b0;
      // Data beats with random ready gaps
      forever begin
        gap = lcg_next() % 2;
        if (gap > 0) begin
          s_wready[k] = 1'b0;
          @(posedge clk);
          #1;
        end
        s_wready[k] = 1'b1;
        do begin
          @(negedge clk);
          hs = s_wvalid[k] && s_wready[k];
          if (hs) begin
            rec_data[k][rec_beats[k] % 16] = s_wdata[k];
            rec_strb[k][rec_beats[k] % 16] = s_wstrb[k];
            rec_last[k][rec_beats[k] % 16] = s_wlast[k];
            rec_beats[k]++;
          end
          @(posedge clk);
        end while (!hs);
        #1;
        if (rec_last[k][(rec_beats[k] - 1) % 16]) begin
          break;
        end
      end
      s_wready[k] = 1'b0;
      s_bvalid[k] = 1'b1;
      s_bid[k]    = rec_id[k];
      s_bresp[k]  = 2'b00;
      do begin
        @(negedge clk);
        hs = s_bvalid[k] && s_bready[k];
        @(posedge clk);
      end while (!hs);
      #1 s_bvalid[k] = 1'b0;
    end
  endtask

  task automatic present_aw(input int n);
    awaddr  = wr_addr[n];
    awid    = wr_id[n];
    awlen   = wr_len[n];
    awsize  = 3'd2;
    awburst = 2'b01;
    awvalid = 1'b1;
  endtask

  task automatic do_write(input int n);
    logic hs;
    cur_addr = wr_addr[n];
    cur_id   = wr_id[n];
    cur_len  = wr_len[n];
    for (int k = 0; k < 2; k++) begin
      rec_aw_cnt[k] = 0;
      rec_beats[k]  = 0;
      valid_seen[k] = 0;
    end
    present_aw(n);
    do begin
      @(negedge clk);
      hs = awvalid && awready;
      @(posedge clk);
    end while (!hs);
    #1 awvalid = 1'b0;
    pending = 1'b1;
    for (int i = 0; i <= int'(cur_len); i++) begin
      cur_data[i] = lcg_next();
      cur_strb[i] = 4'(lcg_next() % 16);
      wdata  = cur_data[i];
      wstrb  = cur_strb[i];
      wlast  = (i == int'(cur_len));
      wvalid = 1'b1;
      do begin
        @(negedge clk);
        hs = wvalid && wready;
        @(posedge clk);
      end while (!hs);
      #1 wvalid = 1'b0;
    end
    // Next address waits at the master while this response is pending
    if (n + 1 < N_WRITES) begin
      present_aw(n + 1);
    end
    bready = 1'b1;
    do begin
      @(negedge clk);
      hs = bvalid && bready;
      got_bid   = bid;
      got_bresp = bresp;
      @(posedge clk);
    end while (!hs);
    #1 bready = 1'b0;
    pending = 1'b0;
    -> write_done;
  endtask

  // Valid activity at the external slaves and the outstanding-write rule
  always @(negedge clk) begin
    if (rstn) begin
      for (int k = 0; k < 2; k++) begin
        if (s_awvalid[k] || s_wvalid[k]) begin
          valid_seen[k]++;
        end
      end
      if (pending) begin
        assert (!awready) else begin
          errors++;
          $display("master AWREADY went high while a response was pending");
        end
      end
    end
  end

  always @(write_done) begin : compare
    int         t;
    int         nbeats;
    logic [7:0] exp_ids;
    logic [1:0] exp_resp;
    t      = expected_write(cur_addr, cur_id, exp_ids, exp_resp);
    nbeats = int'(cur_len) + 1;
    check_val("bresp", 32'(exp_resp), 32'(got_bresp));
    check_val("bid", 32'(cur_id), 32'(got_bid));
    if (t == 2) begin
      check_val("unmapped s0 activity", 0, valid_seen[0]);
      check_val("unmapped s1 activity", 0, valid_seen[1]);
    end else begin
      check_val("other slave activity", 0, valid_seen[1 - t]);
      check_val("aw count", 1, rec_aw_cnt[t]);
      check_val("awid", 32'(exp_ids), 32'(rec_id[t]));
      check_val("awaddr", cur_addr, rec_addr[t]);
      check_val("awlen", 32'(cur_len), 32'(rec_len[t]));
      check_val("awsize", 32'(awsize), 32'(rec_size[t]));
      check_val("awburst", 32'(awburst), 32'(rec_burst[t]));
      check_val("beat count", nbeats, rec_beats[t]);
      for (int i = 0; i < nbeats && i < rec_beats[t]; i++) begin
        check_val("wdata", cur_data[i], rec_data[t][i]);
        check_val("wstrb", 32'(cur_strb[i]), 32'(rec_strb[t][i]));
        check_val("wlast", 32'(i == nbeats - 1), 32'(rec_last[t][i]));
      end
    end
  end

  initial begin
    #(5 * CLK_NS + N_WRITES * 20 * CLK_NS);
    $display("Timeout: the writes did not complete in time");
    $display("test failed");
    $finish;
  end

  initial begin
    logic [31:0] addr;
    int          region;
    clk       = 1'b0;
    rstn      = 1'b0;
    rng_state = 84713;
    errors    = 0;
    pending   = 1'b0;
    {awid, awaddr, awlen, awsize, awburst, awvalid} = '0;
    {wdata, wstrb, wlast, wvalid, bready} = '0;
    for (int k = 0; k < 2; k++) begin
      s_awready[k] = 1'b0;
      s_wready[k]  = 1'b0;
      s_bvalid[k]  = 1'b0;
      s_bid[k]     = '0;
      s_bresp[k]   = '0;
    end
    for (int n = 0; n < N_WRITES; n++) begin
      region = lcg_next() % 3;
      addr   = lcg_next() & 32'h0000_FFFC;
      if (region == 1) begin
        addr[31:16] = 16'h0001;
      end else if (region == 2) begin
        addr[31:16] = 16'(32'h0002 + lcg_next() % 32'hFFF0);
      end
      wr_addr[n] = addr;
      wr_id[n]   = 4'(lcg_next() % 16);
      wr_len[n]  = 4'(lcg_next() % 4);
    end
    repeat (5) @(posedge clk);
    #1 rstn = 1'b1;
    fork
      slave_model(0);
      slave_model(1);
    join_none
    for (int n = 0; n < N_WRITES; n++) begin
      do_write(n);
      // Compare reads this write's record before the next one starts
      #1;
    end
    $display("Writes: %0d, errors: %0d", N_WRITES, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
axi_pkg.sv
axi_chan_if.sv
aw_router.sv
w_router.sv
b_router.sv
default_slave.sv
axi_wr_bridge.sv
tb_axi_wr_bridge_assert.sv
tb_axi_wr_bridge.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_axi_wr_bridge
out=$(./obj_dir/Vtb_axi_wr_bridge) || true
echo "$out"
if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
